// ==== hw/fx_pipe_pkg.sv ====
`default_nettype none

package fx_pipe_pkg;

    // reorder buffer entry id
    typedef logic [3:0] rob_tag_t;

    typedef logic [31:0] word_t;

    // renamed source operand as delivered by dispatch
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    data;
    } src_opnd_t;

    typedef struct packed {
        logic [31:0]     insn;
        src_opnd_t [2:0] src;
        rob_tag_t        dst;
    } dispatch_t;

    // one beat on a result bus, flags are {overflow, illegal}
    typedef struct packed {
        logic       valid;
        rob_tag_t   tag;
        word_t      data;
        logic [1:0] flags;
    } res_bus_t;

endpackage

`default_nettype wire

// ==== hw/fx_op_pkg.sv ====
`default_nettype none

package fx_op_pkg;

    import fx_pipe_pkg::*;

    typedef struct packed {
        logic [4:0] rs3;
        logic [1:0] fmt;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] rm;
        logic [4:0] rd;
        logic [6:0] opcode;
    } fx_insn_r4_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] rm;
        logic [4:0] rd;
        logic [6:0] opcode;
    } fx_insn_r_t;

    // same word, two field layouts
    typedef union packed {
        fx_insn_r4_t r4;
        fx_insn_r_t  r;
    } fx_insn_u;

    // encodings
    localparam logic [6:0] OPC_FP     = 7'b1010011;
    localparam logic [6:0] OPC_MADD   = 7'b1000011;
    localparam logic [6:0] F7_ADD     = 7'h00;
    localparam logic [6:0] F7_SUB     = 7'h04;
    localparam logic [6:0] F7_MUL     = 7'h08;
    localparam logic [6:0] F7_MINMAX  = 7'h14;
    localparam logic [2:0] RM_MIN     = 3'd0;
    localparam logic [2:0] RM_MAX     = 3'd1;

    typedef enum logic [2:0] {
        OP_ADD, OP_SUB, OP_MUL, OP_MADD, OP_MIN, OP_MAX, OP_ILL
    } fx_op_e;

    typedef struct packed {
        logic ovf;
        logic ill;
    } fx_flags_t;

    // queue payload after decode
    typedef struct packed {
        fx_op_e          op;
        src_opnd_t [2:0] src;
        rob_tag_t        dst;
    } fx_decoded_t;

    typedef struct packed {
        fx_op_e   op;
        word_t    a;
        word_t    b;
        word_t    c;
        rob_tag_t dst;
    } fx_req_t;

    typedef struct packed {
        rob_tag_t  tag;
        word_t     data;
        fx_flags_t flags;
    } fx_resp_t;

    // lane latencies in cycles, the longest equals the stage count
    localparam int LAT_SHORT = 1;
    localparam int LAT_MUL   = 3;
    localparam int LAT_MADD  = 4;

endpackage

`default_nettype wire

// ==== hw/fx_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module fx_decode (
    input  wire fx_pipe_pkg::dispatch_t disp_i,
    output fx_op_pkg::fx_decoded_t      payload_o
);
    import fx_op_pkg::*;

    fx_insn_u   insn;
    fx_op_e     op;
    logic [2:0] used;

    always_comb begin
        insn = disp_i.insn;
        op = OP_ILL;
        if (insn.r4.opcode == OPC_MADD) begin
            // only the single format is supported
            if (insn.r4.fmt == 2'b00) begin
                op = OP_MADD;
            end
        end else if (insn.r.opcode == OPC_FP) begin
            case (insn.r.funct7)
                F7_ADD: op = OP_ADD;
                F7_SUB: op = OP_SUB;
                F7_MUL: op = OP_MUL;
                F7_MINMAX: begin
                    if (insn.r.rm == RM_MIN) begin
                        op = OP_MIN;
                    end else if (insn.r.rm == RM_MAX) begin
                        op = OP_MAX;
                    end
                end
                default: op = OP_ILL;
            endcase
        end

        case (op)
            OP_MADD: used = 3'b111;
            OP_ILL:  used = 3'b000;
            default: used = 3'b011;
        endcase
    end

    // unused sources never hold the entry back
    always_comb begin
        payload_o.op = op;
        payload_o.dst = disp_i.dst;
        for (int s = 0; s < 3; s++) begin
            payload_o.src[s] = disp_i.src[s];
            if (!used[s]) begin
                payload_o.src[s].ready = 1'b1;
                payload_o.src[s].tag = '0;
                payload_o.src[s].data = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fx_iq_entry.sv ====
`default_nettype none
`timescale 1ns/1ps

module fx_iq_entry #(
    parameter int SNOOP_CNT = 2
) (
    input  wire                                        clk,
    input  wire                                        rst_n_i,
    input  wire                                        write_i,
    input  wire fx_op_pkg::fx_decoded_t                data_i,
    input  wire                                        issue_i,
    input  wire                                        flush_i,
    input  wire fx_pipe_pkg::res_bus_t [SNOOP_CNT-1:0] snoop_i,
    output logic                                       empty_o,
    output logic                                       ready_o,
    output fx_op_pkg::fx_decoded_t                     data_o
);
    import fx_op_pkg::*;

    fx_decoded_t data_q;
    fx_decoded_t data_next;
    logic        valid_q;
    logic        ready_q;
    logic        occupied_next;
    logic        srcs_ready;

    // wakeup also applies to a beat seen in the write cycle
    always_comb begin
        data_next = write_i ? data_i : data_q;
        for (int s = 0; s < 3; s++) begin
            for (int b = 0; b < SNOOP_CNT; b++) begin
                if (snoop_i[b].valid && !data_next.src[s].ready &&
                        snoop_i[b].tag == data_next.src[s].tag) begin
                    data_next.src[s].ready = 1'b1;
                    data_next.src[s].data = snoop_i[b].data;
                end
            end
        end
        srcs_ready = data_next.src[0].ready && data_next.src[1].ready &&
                     data_next.src[2].ready;
    end

    assign occupied_next = write_i || (valid_q && !issue_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            valid_q <= occupied_next;
            ready_q <= occupied_next && srcs_ready;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_next;
    end

    assign empty_o = !valid_q;
    assign ready_o = ready_q;
    assign data_o = data_q;

    // allocation in the queue must only pick free entries
    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n_i)
        write_i |-> !valid_q);

endmodule

`default_nettype wire

// ==== hw/fx_issue_queue.sv ====
`default_nettype none
`timescale 1ns/1ps

module fx_issue_queue #(
    parameter int IQ_SIZE   = 4,
    parameter int SNOOP_CNT = 2
) (
    input  wire                                        clk,
    input  wire                                        rst_n_i,
    input  wire fx_op_pkg::fx_decoded_t                payload_i,
    input  wire                                        disp_valid_i,
    output logic                                       disp_ready_o,
    input  wire fx_pipe_pkg::res_bus_t [SNOOP_CNT-1:0] snoop_i,
    input  wire                                        flush_i,
    output fx_op_pkg::fx_req_t                         req_o,
    output logic                                       req_valid_o,
    input  wire                                        req_ready_i
);
    import fx_op_pkg::*;

    localparam int CNT_W = $clog2(IQ_SIZE + 1);

    logic [IQ_SIZE-1:0]             empty;
    logic [IQ_SIZE-1:0]             ready;
    logic [IQ_SIZE-1:0]             alloc_oh;
    logic [IQ_SIZE-1:0]             fire_oh;
    fx_decoded_t [IQ_SIZE-1:0]      entry_data;
    logic                           disp_fire;
    logic                           issue_ready;
    logic                           issue_fire;
    logic [CNT_W-1:0]               free_q;
    logic [CNT_W-1:0]               free_next;
    logic [$bits(fx_decoded_t)-1:0] sel_bits;
    fx_decoded_t                    issue_q;
    logic                           issue_valid_q;

    assign disp_fire = disp_valid_i && disp_ready_o;
    assign issue_ready = !issue_valid_q || req_ready_i;
    assign issue_fire = (|fire_oh) && issue_ready;

    // lowest index wins for both allocation and issue
    always_comb begin
        alloc_oh = '0;
        fire_oh = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (empty[i]) begin
                alloc_oh = '0;
                alloc_oh[i] = 1'b1;
            end
            if (ready[i]) begin
                fire_oh = '0;
                fire_oh[i] = 1'b1;
            end
        end
    end

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        fx_iq_entry #(
            .SNOOP_CNT (SNOOP_CNT)
        ) u_entry (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .write_i (alloc_oh[i] && disp_fire),
            .data_i  (payload_i),
            .issue_i (fire_oh[i] && issue_ready),
            .flush_i (flush_i),
            .snoop_i (snoop_i),
            .empty_o (empty[i]),
            .ready_o (ready[i]),
            .data_o  (entry_data[i])
        );
    end

    // ready is held back to leave slack for an in-flight dispatch
    assign free_next = free_q - CNT_W'(disp_fire) + CNT_W'(issue_fire);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            free_q <= CNT_W'(IQ_SIZE);
            disp_ready_o <= 1'b0;
        end else if (flush_i) begin
            free_q <= CNT_W'(IQ_SIZE);
            disp_ready_o <= 1'b1;
        end else begin
            free_q <= free_next;
            disp_ready_o <= free_next >= CNT_W'(2);
        end
    end

    // one-hot mux by OR
    always_comb begin
        sel_bits = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (fire_oh[i]) begin
                sel_bits = sel_bits | entry_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            issue_valid_q <= 1'b0;
        end else if (issue_ready) begin
            issue_valid_q <= |fire_oh;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_ready) begin
            issue_q <= fx_decoded_t'(sel_bits);
        end
    end

    always_comb begin
        req_o.op = issue_q.op;
        req_o.a = issue_q.src[0].data;
        req_o.b = issue_q.src[1].data;
        req_o.c = issue_q.src[2].data;
        req_o.dst = issue_q.dst;
    end

    assign req_valid_o = issue_valid_q;

    // issue only picks an occupied entry
    a_fire_occupied: assert property (@(posedge clk) disable iff (!rst_n_i)
        (fire_oh & empty) == '0);
    a_free_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        free_q <= CNT_W'(IQ_SIZE));

endmodule

`default_nettype wire

// ==== hw/fx_execute.sv ====
`default_nettype none
`timescale 1ns/1ps

module fx_execute (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire fx_op_pkg::fx_req_t req_i,
    input  wire                     req_valid_i,
    output logic                    req_ready_o,
    output fx_op_pkg::fx_resp_t     resp_o,
    output logic                    resp_valid_o,
    input  wire                     resp_ready_i,
    input  wire                     flush_i
);
    import fx_op_pkg::*;

    localparam int STAGES = LAT_MADD;

    // stage STAGES-1 is the result register, ops enter at STAGES-lat
    logic [STAGES-1:0] stg_v_q;
    fx_resp_t [STAGES-1:0] stg_q;
    fx_resp_t res;
    int lat;
    logic slot_busy;
    logic stall;
    logic accept;
    logic [2:0] inflight_q;

    always_comb begin
        res.tag = req_i.dst;
        res.data = '0;
        res.flags = '0;
        lat = LAT_SHORT;
        case (req_i.op)
            OP_ADD: begin
                res.data = req_i.a + req_i.b;
                res.flags.ovf = (req_i.a[31] == req_i.b[31]) && (res.data[31] != req_i.a[31]);
            end
            OP_SUB: begin
                res.data = req_i.a - req_i.b;
                res.flags.ovf = (req_i.a[31] != req_i.b[31]) && (res.data[31] != req_i.a[31]);
            end
            OP_MUL: begin
                res.data = req_i.a * req_i.b;
                lat = LAT_MUL;
            end
            OP_MADD: begin
                res.data = req_i.a * req_i.b + req_i.c;
                lat = LAT_MADD;
            end
            OP_MIN: res.data = ($signed(req_i.a) < $signed(req_i.b)) ? req_i.a : req_i.b;
            OP_MAX: res.data = ($signed(req_i.a) > $signed(req_i.b)) ? req_i.a : req_i.b;
            default: res.flags.ill = 1'b1;
        endcase
    end

    // the stage shifting into the entry slot reserves it
    assign slot_busy = (lat < STAGES) ? stg_v_q[STAGES-1-lat] : 1'b0;
    assign stall = stg_v_q[STAGES-1] && !resp_ready_i;
    assign req_ready_o = !stall && !slot_busy;
    assign accept = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            stg_v_q <= '0;
        end else if (!stall) begin
            stg_v_q <= {stg_v_q[STAGES-2:0], 1'b0};
            if (accept) begin
                stg_v_q[STAGES-lat] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int k = STAGES - 1; k > 0; k--) begin
                stg_q[k] <= stg_q[k-1];
            end
            if (accept) begin
                stg_q[STAGES-lat] <= res;
            end
        end
    end

    assign resp_o = stg_q[STAGES-1];
    assign resp_valid_o = stg_v_q[STAGES-1];

    // ops in flight, a slot collision would lose one of them
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            inflight_q <= '0;
        end else begin
            inflight_q <= inflight_q + 3'(accept) - 3'(resp_valid_o && resp_ready_i);
        end
    end

    a_slot_unique: assert property (@(posedge clk) disable iff (!rst_n_i)
        $countones(stg_v_q) == int'(inflight_q));

endmodule

`default_nettype wire

// ==== hw/fx_result_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module fx_result_fifo (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire fx_op_pkg::fx_resp_t in_i,
    input  wire                      in_valid_i,
    output logic                     in_ready_o,
    output fx_pipe_pkg::res_bus_t    out_o,
    input  wire                      out_ready_i,
    input  wire                      flush_i
);
    import fx_op_pkg::*;

    fx_resp_t [1:0] mem;
    logic           wr_ptr_q;
    logic           rd_ptr_q;
    logic [1:0]     cnt_q;
    logic           wr_en;
    logic           rd_en;

    assign in_ready_o = cnt_q != 2'd2;
    assign wr_en = in_valid_i && in_ready_o;
    assign rd_en = out_o.valid && out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q ^ wr_en;
            rd_ptr_q <= rd_ptr_q ^ rd_en;
            cnt_q <= cnt_q + 2'(wr_en) - 2'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= in_i;
        end
    end

    // head entry shows on the bus
    always_comb begin
        out_o.valid = cnt_q != 2'd0;
        out_o.tag = mem[rd_ptr_q].tag;
        out_o.data = mem[rd_ptr_q].data;
        out_o.flags = mem[rd_ptr_q].flags;
    end

    // a beat refused while full must be held by execute
    a_full_hold: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_i));

endmodule

`default_nettype wire

// ==== hw/fx_ooo_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module fx_ooo_unit #(
    parameter int IQ_SIZE   = 4,
    parameter int SNOOP_CNT = 2
) (
    input  wire                                        clk,
    input  wire                                        rst_n_i,
    input  wire fx_pipe_pkg::dispatch_t                disp_i,
    input  wire                                        disp_valid_i,
    output logic                                       disp_ready_o,
    input  wire fx_pipe_pkg::res_bus_t [SNOOP_CNT-1:0] snoop_i,
    output fx_pipe_pkg::res_bus_t                      res_o,
    input  wire                                        res_ready_i,
    input  wire                                        flush_i
);
    import fx_op_pkg::*;

    fx_decoded_t payload;
    fx_req_t     req;
    logic        req_valid;
    logic        req_ready;
    fx_resp_t    resp;
    logic        resp_valid;
    logic        resp_ready;

    fx_decode u_decode (
        .disp_i    (disp_i),
        .payload_o (payload)
    );

    fx_issue_queue #(
        .IQ_SIZE   (IQ_SIZE),
        .SNOOP_CNT (SNOOP_CNT)
    ) u_iq (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .payload_i    (payload),
        .disp_valid_i (disp_valid_i),
        .disp_ready_o (disp_ready_o),
        .snoop_i      (snoop_i),
        .flush_i      (flush_i),
        .req_o        (req),
        .req_valid_o  (req_valid),
        .req_ready_i  (req_ready)
    );

    fx_execute u_exec (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .resp_o       (resp),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .flush_i      (flush_i)
    );

    fx_result_fifo u_fifo (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_i        (resp),
        .in_valid_i  (resp_valid),
        .in_ready_o  (resp_ready),
        .out_o       (res_o),
        .out_ready_i (res_ready_i),
        .flush_i     (flush_i)
    );

endmodule

`default_nettype wire

// ==== sim/fx_ooo_unit_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module fx_ooo_unit_tb;
    import fx_pipe_pkg::*;
    import fx_op_pkg::*;

    localparam int TO = 2000;

    logic clk;
    logic rst_n_i;
    dispatch_t disp_i;
    logic disp_valid_i;
    logic disp_ready_o;
    res_bus_t snoop0 = '0;
    res_bus_t snoop1 = '0;
    res_bus_t [1:0] snoop_bus;
    res_bus_t res_o;
    logic res_ready_i = 1'b1;
    logic flush_i;

    // scoreboard keyed by rob tag
    logic [15:0] live;
    logic [15:0] waiting;
    logic [15:0] flushed;
    word_t exp_data [16];
    logic [1:0] exp_flags [16];
    int ret_seq [16];
    int seq_cnt;
    int outstanding;
    int errors;
    int checks;
    logic [31:0] lfsr_q = 32'h25db_156a;
    int rr_mode;
    res_bus_t acc_beat;
    rob_tag_t mon_tag;
    rob_tag_t next_tag;

    assign snoop_bus = {snoop1, snoop0};

    fx_ooo_unit #(.IQ_SIZE(4), .SNOOP_CNT(2)) dut0 (
        .clk(clk), .rst_n_i(rst_n_i), .disp_i(disp_i), .disp_valid_i(disp_valid_i),
        .disp_ready_o(disp_ready_o), .snoop_i(snoop_bus), .res_o(res_o),
        .res_ready_i(res_ready_i), .flush_i(flush_i)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // sel 0..5 are legal ops and 6..9 illegal encodings
    function automatic logic [31:0] encode_insn(input int sel);
        fx_insn_u u;
        u = '0;
        u.r.rd = 5'(sel);
        u.r.rs1 = 5'd1;
        u.r.rs2 = 5'd2;
        u.r.opcode = OPC_FP;
        case (sel)
            0: u.r.funct7 = F7_ADD;
            1: u.r.funct7 = F7_SUB;
            2: u.r.funct7 = F7_MUL;
            3: begin
                u.r4.opcode = OPC_MADD;
                u.r4.fmt = 2'b00;
                u.r4.rs3 = 5'd3;
            end
            4: begin
                u.r.funct7 = F7_MINMAX;
                u.r.rm = RM_MIN;
            end
            5: begin
                u.r.funct7 = F7_MINMAX;
                u.r.rm = RM_MAX;
            end
            6: u.r.funct7 = 7'h7f;
            7: begin
                u.r4.opcode = OPC_MADD;
                u.r4.fmt = 2'b01;
            end
            8: u.r.opcode = 7'h33;
            default: begin
                u.r.funct7 = F7_MINMAX;
                u.r.rm = 3'd5;
            end
        endcase
        return u;
    endfunction

    // flags are {overflow, illegal}
    task automatic compute_expected(input int sel, input word_t a, input word_t b,
                                    input word_t c, output word_t d, output logic [1:0] f);
        logic [32:0] wide;
        logic [63:0] prod;
        d = '0;
        f = 2'b00;
        prod = {32'b0, a} * {32'b0, b};
        case (sel)
            0, 1: begin
                wide = (sel == 0) ? {a[31], a} + {b[31], b} : {a[31], a} - {b[31], b};
                d = wide[31:0];
                f[1] = wide[32] ^ wide[31];
            end
            2: d = prod[31:0];
            3: d = prod[31:0] + c;
            // signed compare by flipping the sign bit
            4: d = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? a : b;
            5: d = ((a ^ 32'h8000_0000) > (b ^ 32'h8000_0000)) ? a : b;
            default: f = 2'b01;
        endcase
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("checks=%0d errors=%0d", checks, errors);
        $display("Regression failed");
        $finish;
    endtask

    task automatic dispatch_one(input int sel, input word_t a, input word_t b, input word_t c,
                                input logic [2:0] pend, output rob_tag_t tag);
        dispatch_t d;
        word_t vals [3];
        word_t ed;
        logic [1:0] ef;
        int t;
        tag = next_tag;
        next_tag = (next_tag == 4'd11) ? 4'd0 : next_tag + 4'd1;
        vals[0] = a;
        vals[1] = b;
        vals[2] = c;
        t = 0;
        @(negedge clk);
        while (live[tag]) begin
            t++;
            if (t > TO) fail_timeout("a free rob tag");
            @(negedge clk);
        end
        d.insn = encode_insn(sel);
        d.dst = tag;
        for (int s = 0; s < 3; s++) begin
            d.src[s].ready = !pend[s];
            d.src[s].tag = rob_tag_t'(12 + s);
            d.src[s].data = pend[s] ? 32'h0 : vals[s];
        end
        compute_expected(sel, a, b, c, ed, ef);
        @(posedge clk);
        disp_valid_i <= 1'b1;
        disp_i <= d;
        t = 0;
        @(negedge clk);
        while (!disp_ready_o) begin
            t++;
            if (t > TO) fail_timeout("disp_ready_o");
            @(negedge clk);
        end
        @(posedge clk);
        disp_valid_i <= 1'b0;
        live[tag] = 1'b1;
        flushed[tag] = 1'b0;
        waiting[tag] = (pend != 3'b000) && (sel < 6);
        exp_data[tag] = ed;
        exp_flags[tag] = ef;
        outstanding++;
    endtask

    task automatic produce_beat(input rob_tag_t ptag, input word_t data, input rob_tag_t waiter);
        res_bus_t b;
        b.valid = 1'b1;
        b.tag = ptag;
        b.data = data;
        b.flags = 2'b00;
        @(posedge clk);
        snoop1 <= b;
        waiting[waiter] = 1'b0;
        @(posedge clk);
        snoop1 <= '0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        @(negedge clk);
        while (outstanding != 0) begin
            t++;
            if (t > TO) fail_timeout("all results to return");
            @(negedge clk);
        end
    endtask

    // a beat moves when valid and ready meet at the coming edge
    always @(negedge clk) begin
        acc_beat = '0;
        if (rst_n_i && res_o.valid && res_ready_i) begin
            acc_beat = res_o;
            mon_tag = res_o.tag;
            checks++;
            assert (!flushed[mon_tag]) else begin
                $display("beat for flushed tag %0d appeared", mon_tag);
                errors++;
            end
            assert (live[mon_tag] || flushed[mon_tag]) else begin
                $display("unexpected or duplicate beat for tag %0d", mon_tag);
                errors++;
            end
            assert (!waiting[mon_tag]) else begin
                $display("tag %0d returned before its producer beat", mon_tag);
                errors++;
            end
            if (live[mon_tag]) begin
                assert (res_o.data == exp_data[mon_tag]) else begin
                    $display("ERR res_o.data tag %h exp %h got %h", mon_tag,
                             exp_data[mon_tag], res_o.data);
                    errors++;
                end
                assert (res_o.flags == exp_flags[mon_tag]) else begin
                    $display("ERR res_o.flags tag %h exp %h got %h", mon_tag,
                             exp_flags[mon_tag], res_o.flags);
                    errors++;
                end
                live[mon_tag] = 1'b0;
                ret_seq[mon_tag] = seq_cnt;
                seq_cnt++;
                outstanding--;
            end
        end
    end

    // loopback onto snoop lane 0
    always @(posedge clk) begin
        snoop0 <= acc_beat;
        case (rr_mode)
            0: res_ready_i <= 1'b1;
            1: res_ready_i <= take_bits(1) != 32'h0;
            default: res_ready_i <= 1'b0;
        endcase
    end

    initial begin
        rob_tag_t tg;
        rob_tag_t tm;
        int n;
        int t;
        clk = 1'b0;
        rst_n_i = 1'b0;
        disp_i = '0;
        disp_valid_i = 1'b0;
        flush_i = 1'b0;
        live = '0;
        waiting = '0;
        flushed = '0;
        seq_cnt = 0;
        outstanding = 0;
        errors = 0;
        checks = 0;
        rr_mode = 0;
        acc_beat = '0;
        next_tag = '0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert (!disp_ready_o && !res_o.valid) else begin
            $display("outputs not idle right after reset");
            errors++;
        end

        // directed ops, overflow cases and illegal encodings
        dispatch_one(0, 32'h7fff_ffff, 32'h1, 32'h0, 3'b000, tg);
        dispatch_one(1, 32'h8000_0000, 32'h1, 32'h0, 3'b000, tg);
        dispatch_one(2, 32'hffff_fff3, 32'h0001_0007, 32'h0, 3'b000, tg);
        dispatch_one(3, 32'h0000_1234, 32'h0000_0100, 32'h5, 3'b000, tg);
        dispatch_one(4, 32'hffff_fff0, 32'h0000_0003, 32'h0, 3'b000, tg);
        dispatch_one(5, 32'hffff_fff0, 32'h0000_0003, 32'h0, 3'b000, tg);
        for (int s = 6; s < 10; s++) begin
            dispatch_one(s, 32'h11, 32'h22, 32'h33, 3'b000, tg);
        end
        wait_drain();

        // madd then an independent add two cycles behind it
        dispatch_one(3, 32'h3, 32'h4, 32'h5, 3'b000, tm);
        dispatch_one(0, 32'h10, 32'h20, 32'h0, 3'b000, tg);
        wait_drain();
        assert ((ret_seq[tg] < ret_seq[tm]) == (LAT_SHORT + 2 < LAT_MADD)) else begin
            $display("madd and add completed in the wrong order");
            errors++;
        end

        // wakeup on snoop lane 1
        dispatch_one(2, 32'h0000_1234, 32'h3, 32'h0, 3'b001, tg);
        repeat (12) @(posedge clk);
        produce_beat(4'd12, 32'h0000_1234, tg);
        wait_drain();

        rr_mode = 1;
        repeat (40) begin
            @(negedge clk);
            n = int'(take_bits(4) % 32'd10);
            dispatch_one(n, take_bits(32), take_bits(32), take_bits(32), 3'b000, tg);
        end
        wait_drain();

        // result bus stalled until dispatch is refused
        rr_mode = 2;
        n = 0;
        @(negedge clk);
        while (disp_ready_o && n < 11) begin
            dispatch_one(0, n, 32'h100, 32'h0, 3'b000, tg);
            n++;
            @(negedge clk);
        end
        assert (!disp_ready_o && n >= 4) else begin
            $display("disp_ready_o did not fall under back-pressure");
            errors++;
        end
        rr_mode = 1;
        wait_drain();

        rr_mode = 2;
        dispatch_one(3, 32'h7, 32'h8, 32'h9, 3'b001, tg);
        dispatch_one(2, 32'h5, 32'h6, 32'h0, 3'b000, tg);
        dispatch_one(0, 32'h1, 32'h2, 32'h0, 3'b000, tg);
        repeat (3) @(posedge clk);
        flush_i <= 1'b1;
        flushed = flushed | live;
        live = '0;
        waiting = '0;
        outstanding = 0;
        @(posedge clk);
        flush_i <= 1'b0;
        t = 0;
        @(negedge clk);
        rr_mode = 0;
        while (!disp_ready_o) begin
            t++;
            if (t > TO) fail_timeout("disp_ready_o after flush");
            @(negedge clk);
        end
        repeat (10) @(posedge clk);
        dispatch_one(1, 32'h50, 32'h8, 32'h0, 3'b000, tg);
        dispatch_one(3, 32'h2, 32'h3, 32'h4, 3'b000, tg);
        dispatch_one(5, 32'h9, 32'hffff_ffff, 32'h0, 3'b000, tg);
        wait_drain();

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fx_ooo_unit.f ====
hw/fx_pipe_pkg.sv
hw/fx_op_pkg.sv
hw/fx_decode.sv
hw/fx_iq_entry.sv
hw/fx_issue_queue.sv
hw/fx_execute.sv
hw/fx_result_fifo.sv
hw/fx_ooo_unit.sv
sim/fx_ooo_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fx_ooo_unit_tb
FILELIST  ?= fx_ooo_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "Regression failed" $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
